// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_ss_scan_controller
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/scan_chain_shifter.sv
// --------------------
// Scan chain shifter
// Parallel load, then one serial bit per lane, MSB first
// --------------------

`default_nettype none

module scan_chain_shifter #(
    parameter int LANES  = 1,
    parameter int LENGTH = 28
) (
    input  wire                      i_sys_clk,
    input  wire                      rst_sync_sys,
    input  wire                      i_load,
    input  wire [LANES*LENGTH-1:0]   i_data,
    input  wire                      i_shift,
    output logic [LANES-1:0]         o_serial
);

    genvar l;

    // Lane l takes frame bits l*LENGTH up to l*LENGTH+LENGTH-1
    for (l = 0; l < LANES; l++) begin : g_lane
        logic [LENGTH-1:0] lane_q;

        always_ff @(posedge i_sys_clk or posedge rst_sync_sys) begin
            if (rst_sync_sys) begin
                lane_q <= '0;
            end else if (i_load) begin
                lane_q <= i_data[l*LENGTH +: LENGTH];
            end else if (i_shift) begin
                lane_q <= {lane_q[LENGTH-2:0], 1'b0};
            end
        end

        // Chip sees the top bit of each lane
        assign o_serial[l] = lane_q[LENGTH-1];
    end

endmodule

`default_nettype wire

// File: rtl/scan_clk_gen.sv
// --------------------
// Scan clock generator
// Divides the system clock into complementary scan clocks
// and flags the cycles ahead of each scan edge
// --------------------

`default_nettype none

`include "ss_defs.svh"

module scan_clk_gen (
    input  wire  i_sys_clk,
    input  wire  rst_sync_sys,
    input  wire  i_enable,
    output logic o_scan_clk_p,
    output logic o_scan_clk_n,
    output logic o_rise_tick,
    output logic o_fall_tick
);

    localparam int DIV   = `SS_SCAN_CLK_DIV;
    localparam int HALF  = DIV / 2;
    localparam int CNT_W = $clog2(DIV);

    logic [CNT_W-1:0] div_cnt;
    logic [CNT_W-1:0] cnt_nxt;
    logic             clk_p_nxt;

    assign cnt_nxt   = (div_cnt == CNT_W'(DIV - 1)) ? '0 : div_cnt + 1'b1;
    // High half of the period is the first HALF counts
    assign clk_p_nxt = (cnt_nxt < CNT_W'(HALF));

    // Edges happen at the end of these cycles
    assign o_rise_tick = i_enable && (div_cnt == CNT_W'(DIV - 1));
    assign o_fall_tick = i_enable && (div_cnt == CNT_W'(HALF - 1));

    // Start in the low half so the first edge is a rising one
    always_ff @(posedge i_sys_clk or posedge rst_sync_sys) begin
        if (rst_sync_sys) begin
            div_cnt      <= CNT_W'(HALF);
            o_scan_clk_p <= 1'b0;
            o_scan_clk_n <= 1'b0;
        end else if (i_enable) begin
            div_cnt      <= cnt_nxt;
            o_scan_clk_p <= clk_p_nxt;
            o_scan_clk_n <= ~clk_p_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/scan_cmd_dispatch.sv
// --------------------
// Host command dispatcher
// Registers a command and starts the target channel,
// or flags the command as dropped when that channel is busy
// --------------------

`default_nettype none

`include "ss_defs.svh"

module scan_cmd_dispatch
    import ss_pkg::*;
(
    input  wire                                 i_sys_clk,
    input  wire                                 rst_sync_sys,
    input  wire                                 i_cmd_valid,
    input  wire scan_op_e                       i_cmd_op,
    input  wire [$clog2(`SS_NUM_CHANNELS)-1:0]  i_cmd_channel,
    input  wire [`SS_ADDR_CHAIN_LEN-1:0]        i_cmd_addr,
    input  wire [`SS_FRAME_WIDTH-1:0]           i_cmd_inst,
    input  wire [`SS_NUM_CHANNELS-1:0]          i_busy,
    output logic [`SS_NUM_CHANNELS-1:0]         o_start,
    output scan_op_e                            o_op,
    output logic [`SS_ADDR_CHAIN_LEN-1:0]       o_addr,
    output logic [`SS_FRAME_WIDTH-1:0]          o_inst,
    output logic                                o_cmd_drop
);

    logic busy_eff;
    logic accept;
    logic drop_q;

    // A start issued this cycle has not reached the driver's busy yet
    assign busy_eff = i_busy[i_cmd_channel] | o_start[i_cmd_channel];
    assign accept   = i_cmd_valid && !busy_eff;

    // --------------------
    // Start and drop strobes
    // --------------------
    always_ff @(posedge i_sys_clk or posedge rst_sync_sys) begin
        if (rst_sync_sys) begin
            o_start    <= '0;
            drop_q     <= 1'b0;
            o_cmd_drop <= 1'b0;
        end else begin
            o_start    <= '0;
            drop_q     <= i_cmd_valid && busy_eff;
            o_cmd_drop <= drop_q;
            if (accept) begin
                o_start[i_cmd_channel] <= 1'b1;
            end
        end
    end

    // --------------------
    // Shared payload bus
    // --------------------
    // Only accepted commands reach the bus
    always_ff @(posedge i_sys_clk) begin
        if (accept) begin
            o_op   <= i_cmd_op;
            o_addr <= i_cmd_addr;
            o_inst <= i_cmd_inst;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ss_channel_driver.sv
// --------------------
// Superswitch channel driver
// Sequences chip reset, address load and instruction load
// on the scan ticks, pulses update and captures loopback
// --------------------

`default_nettype none

`include "ss_defs.svh"

module ss_channel_driver
    import ss_pkg::*;
(
    input  wire                               i_sys_clk,
    input  wire                               rst_sync_sys,
    input  wire                               i_start,
    input  wire scan_op_e                     i_op,
    input  wire [`SS_ADDR_CHAIN_LEN-1:0]      i_addr,
    input  wire [`SS_FRAME_WIDTH-1:0]         i_inst,
    input  wire                               i_rise_tick,
    input  wire                               i_fall_tick,
    input  wire                               i_scan_out_loopback,
    output logic                              o_busy,
    output logic                              o_done,
    output logic                              o_loopback_valid,
    output logic [`SS_INST_CHAIN_LEN-1:0]     o_loopback_data,
    output logic                              o_scan_reset,
    output logic                              o_scan_update,
    output logic                              o_scan_en_inst,
    output logic [`SS_NUM_INST_CHAINS-1:0]    o_scan_in_inst,
    output logic                              o_scan_en_address,
    output logic                              o_scan_in_address
);

    localparam int LEN_MAX = (`SS_ADDR_CHAIN_LEN > `SS_INST_CHAIN_LEN) ?
                             `SS_ADDR_CHAIN_LEN : `SS_INST_CHAIN_LEN;
    localparam int TICK_MAX = (LEN_MAX > `SS_RESET_TICKS) ? LEN_MAX : `SS_RESET_TICKS;
    localparam int CNT_W = $clog2(TICK_MAX + 1);

    drv_state_e                    state;
    scan_op_e                      op_q;
    logic [CNT_W-1:0]              tick_cnt;
    logic [`SS_INST_CHAIN_LEN-1:0] lb_shift;
    logic                          addr_last;
    logic                          inst_last;
    logic                          addr_shift;
    logic                          inst_shift;

    // Counts rise ticks, i.e. bits the chip has sampled
    assign addr_last = (tick_cnt == CNT_W'(`SS_ADDR_CHAIN_LEN));
    assign inst_last = (tick_cnt == CNT_W'(`SS_INST_CHAIN_LEN));

    // Next bit goes out on the falling scan edge
    assign addr_shift = (state == ST_SHIFT_ADDR) && i_fall_tick &&
                        o_scan_en_address && !addr_last;
    assign inst_shift = (state == ST_SHIFT_INST) && i_fall_tick &&
                        o_scan_en_inst && !inst_last;

    assign o_busy           = (state != ST_IDLE);
    assign o_done           = (state == ST_DONE);
    assign o_loopback_valid = o_done && (op_q == OP_LOAD_INST);

    // --------------------
    // Chain shifters
    // --------------------
    scan_chain_shifter #(
        .LANES  (1),
        .LENGTH (`SS_ADDR_CHAIN_LEN)
    ) u_addr_shifter (
        .i_sys_clk    (i_sys_clk),
        .rst_sync_sys (rst_sync_sys),
        .i_load       (i_start),
        .i_data       (i_addr),
        .i_shift      (addr_shift),
        .o_serial     (o_scan_in_address)
    );

    scan_chain_shifter #(
        .LANES  (`SS_NUM_INST_CHAINS),
        .LENGTH (`SS_INST_CHAIN_LEN)
    ) u_inst_shifter (
        .i_sys_clk    (i_sys_clk),
        .rst_sync_sys (rst_sync_sys),
        .i_load       (i_start),
        .i_data       (i_inst),
        .i_shift      (inst_shift),
        .o_serial     (o_scan_in_inst)
    );

    // --------------------
    // Sequencer
    // --------------------
    always_ff @(posedge i_sys_clk or posedge rst_sync_sys) begin
        if (rst_sync_sys) begin
            state             <= ST_IDLE;
            op_q              <= OP_RESET_CHIP;
            tick_cnt          <= '0;
            o_loopback_data   <= '0;
            o_scan_reset      <= 1'b0;
            o_scan_update     <= 1'b0;
            o_scan_en_inst    <= 1'b0;
            o_scan_en_address <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        op_q     <= i_op;
                        tick_cnt <= '0;
                        case (i_op)
                            OP_RESET_CHIP: state <= ST_RESET;
                            OP_LOAD_ADDR:  state <= ST_SHIFT_ADDR;
                            OP_LOAD_INST:  state <= ST_SHIFT_INST;
                            default:       state <= ST_IDLE;
                        endcase
                    end
                end
                // First fall tick raises the strobe, later ones may end it
                ST_RESET: begin
                    if (i_rise_tick && o_scan_reset) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (i_fall_tick) begin
                        if (!o_scan_reset) begin
                            o_scan_reset <= 1'b1;
                        end else if (tick_cnt == CNT_W'(`SS_RESET_TICKS)) begin
                            o_scan_reset <= 1'b0;
                            state        <= ST_DONE;
                        end
                    end
                end
                ST_SHIFT_ADDR: begin
                    if (i_rise_tick && o_scan_en_address) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (i_fall_tick) begin
                        if (!o_scan_en_address) begin
                            o_scan_en_address <= 1'b1;
                        end else if (addr_last) begin
                            o_scan_en_address <= 1'b0;
                            o_scan_update     <= 1'b1;
                            state             <= ST_UPDATE;
                        end
                    end
                end
                ST_SHIFT_INST: begin
                    if (i_rise_tick && o_scan_en_inst) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (i_fall_tick) begin
                        if (!o_scan_en_inst) begin
                            o_scan_en_inst <= 1'b1;
                        end else if (inst_last) begin
                            o_scan_en_inst  <= 1'b0;
                            o_scan_update   <= 1'b1;
                            o_loopback_data <= lb_shift;
                            state           <= ST_UPDATE;
                        end
                    end
                end
                // Update spans one full scan period
                ST_UPDATE: begin
                    if (i_fall_tick) begin
                        o_scan_update <= 1'b0;
                        state         <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Loopback word builds MSB first, sampled ahead of each rising edge
    always_ff @(posedge i_sys_clk) begin
        if (i_rise_tick && o_scan_en_inst) begin
            lb_shift <= {lb_shift[`SS_INST_CHAIN_LEN-2:0], i_scan_out_loopback};
        end
    end

endmodule

`default_nettype wire

// File: rtl/ss_defs.svh
// --------------------
// Superswitch scan controller constants
// Chip geometry, channel count and scan timing
// --------------------

`ifndef SS_DEFS_SVH
`define SS_DEFS_SVH

// Chips driven in parallel
`define SS_NUM_CHANNELS 4

// Chain geometry of one chip
`define SS_NUM_INST_CHAINS 8
`define SS_INST_CHAIN_LEN 28
`define SS_ADDR_CHAIN_LEN 28

// One instruction frame holds every lane back to back
`define SS_FRAME_WIDTH (`SS_NUM_INST_CHAINS * `SS_INST_CHAIN_LEN)

// System clock cycles per scan clock period
`define SS_SCAN_CLK_DIV 4

// Scan ticks that scan reset stays asserted
`define SS_RESET_TICKS 4

`endif

// File: rtl/ss_pkg.sv
// --------------------
// Superswitch scan controller types
// Operation codes and channel driver states
// --------------------

`default_nettype none

package ss_pkg;

    // Host operations on one scan channel
    typedef enum logic [1:0] {
        OP_RESET_CHIP = 2'd0,
        OP_LOAD_ADDR  = 2'd1,
        OP_LOAD_INST  = 2'd2
    } scan_op_e;

    // Channel driver sequencer
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_RESET      = 3'd1,
        ST_SHIFT_ADDR = 3'd2,
        ST_SHIFT_INST = 3'd3,
        ST_UPDATE     = 3'd4,
        ST_DONE       = 3'd5
    } drv_state_e;

endpackage

`default_nettype wire

// File: rtl/ss_scan_controller.sv
// --------------------
// Superswitch scan controller
// Drives four chips in parallel from host commands
// on scan clocks derived from the system clock
// --------------------

`default_nettype none

`include "ss_defs.svh"

module ss_scan_controller
    import ss_pkg::*;
(
    input  wire                                                   i_sys_clk,
    input  wire                                                   rst_sync_sys,
    input  wire                                                   i_scan_clk_en,
    // Host command
    input  wire                                                   i_cmd_valid,
    input  wire scan_op_e                                         i_cmd_op,
    input  wire [$clog2(`SS_NUM_CHANNELS)-1:0]                    i_cmd_channel,
    input  wire [`SS_ADDR_CHAIN_LEN-1:0]                          i_cmd_addr,
    input  wire [`SS_FRAME_WIDTH-1:0]                             i_cmd_inst,
    output wire                                                   o_cmd_drop,
    // Per-channel completion
    output wire [`SS_NUM_CHANNELS-1:0]                            o_done,
    output wire [`SS_NUM_CHANNELS-1:0]                            o_loopback_valid,
    output wire [`SS_NUM_CHANNELS-1:0][`SS_INST_CHAIN_LEN-1:0]    o_loopback_data,
    // Chip scan pins
    output wire                                                   o_scan_clk_p,
    output wire                                                   o_scan_clk_n,
    output wire [`SS_NUM_CHANNELS-1:0]                            o_scan_reset,
    output wire [`SS_NUM_CHANNELS-1:0]                            o_scan_update,
    output wire [`SS_NUM_CHANNELS-1:0]                            o_scan_en_inst,
    output wire [`SS_NUM_CHANNELS-1:0][`SS_NUM_INST_CHAINS-1:0]   o_scan_in_inst,
    output wire [`SS_NUM_CHANNELS-1:0]                            o_scan_en_address,
    output wire [`SS_NUM_CHANNELS-1:0]                            o_scan_in_address,
    input  wire [`SS_NUM_CHANNELS-1:0]                            i_scan_out_loopback
);

    genvar ch;

    logic                            rise_tick;
    logic                            fall_tick;
    logic [`SS_NUM_CHANNELS-1:0]     start;
    logic [`SS_NUM_CHANNELS-1:0]     busy;
    scan_op_e                        op_bus;
    logic [`SS_ADDR_CHAIN_LEN-1:0]   addr_bus;
    logic [`SS_FRAME_WIDTH-1:0]      inst_bus;

    // --------------------
    // Shared scan timing
    // --------------------
    scan_clk_gen u_clk_gen (
        .i_sys_clk    (i_sys_clk),
        .rst_sync_sys (rst_sync_sys),
        .i_enable     (i_scan_clk_en),
        .o_scan_clk_p (o_scan_clk_p),
        .o_scan_clk_n (o_scan_clk_n),
        .o_rise_tick  (rise_tick),
        .o_fall_tick  (fall_tick)
    );

    scan_cmd_dispatch u_dispatch (
        .i_sys_clk     (i_sys_clk),
        .rst_sync_sys  (rst_sync_sys),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd_op      (i_cmd_op),
        .i_cmd_channel (i_cmd_channel),
        .i_cmd_addr    (i_cmd_addr),
        .i_cmd_inst    (i_cmd_inst),
        .i_busy        (busy),
        .o_start       (start),
        .o_op          (op_bus),
        .o_addr        (addr_bus),
        .o_inst        (inst_bus),
        .o_cmd_drop    (o_cmd_drop)
    );

    // --------------------
    // One driver per chip
    // --------------------
    for (ch = 0; ch < `SS_NUM_CHANNELS; ch++) begin : g_chan
        ss_channel_driver u_driver (
            .i_sys_clk           (i_sys_clk),
            .rst_sync_sys        (rst_sync_sys),
            .i_start             (start[ch]),
            .i_op                (op_bus),
            .i_addr              (addr_bus),
            .i_inst              (inst_bus),
            .i_rise_tick         (rise_tick),
            .i_fall_tick         (fall_tick),
            .i_scan_out_loopback (i_scan_out_loopback[ch]),
            .o_busy              (busy[ch]),
            .o_done              (o_done[ch]),
            .o_loopback_valid    (o_loopback_valid[ch]),
            .o_loopback_data     (o_loopback_data[ch]),
            .o_scan_reset        (o_scan_reset[ch]),
            .o_scan_update       (o_scan_update[ch]),
            .o_scan_en_inst      (o_scan_en_inst[ch]),
            .o_scan_in_inst      (o_scan_in_inst[ch]),
            .o_scan_en_address   (o_scan_en_address[ch]),
            .o_scan_in_address   (o_scan_in_address[ch])
        );
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/ss_pkg.sv
rtl/scan_clk_gen.sv
rtl/scan_cmd_dispatch.sv
rtl/scan_chain_shifter.sv
rtl/ss_channel_driver.sv
rtl/ss_scan_controller.sv
verification/tb_ss_scan_controller.sv

// File: verification/tb_ss_scan_controller.sv
// --------------------
// Superswitch scan controller testbench
// Drives host commands into the DUT, models four chips
// and checks applied chains, loopback and drops
// --------------------

`default_nettype none

`include "ss_defs.svh"

module tb_ss_scan_controller
    import ss_pkg::*;
();

    localparam int NCH  = `SS_NUM_CHANNELS;
    localparam int NL   = `SS_NUM_INST_CHAINS;
    localparam int LEN  = `SS_INST_CHAIN_LEN;
    localparam int ALEN = `SS_ADDR_CHAIN_LEN;
    localparam int FW   = `SS_FRAME_WIDTH;
    localparam int TIMEOUT_CYCLES = 20000;

    logic                      i_sys_clk;
    logic                      rst_sync_sys;
    logic                      i_scan_clk_en;
    logic                      i_cmd_valid;
    scan_op_e                  i_cmd_op;
    logic [1:0]                i_cmd_channel;
    logic [ALEN-1:0]           i_cmd_addr;
    logic [FW-1:0]             i_cmd_inst;
    logic                      o_cmd_drop;
    logic [NCH-1:0]            o_done;
    logic [NCH-1:0]            o_loopback_valid;
    logic [NCH-1:0][LEN-1:0]   o_loopback_data;
    logic                      o_scan_clk_p;
    logic                      o_scan_clk_n;
    logic [NCH-1:0]            o_scan_reset;
    logic [NCH-1:0]            o_scan_update;
    logic [NCH-1:0]            o_scan_en_inst;
    logic [NCH-1:0][NL-1:0]    o_scan_in_inst;
    logic [NCH-1:0]            o_scan_en_address;
    logic [NCH-1:0]            o_scan_in_address;
    logic [NCH-1:0]            scan_loopback;

    // Chip model state
    logic [ALEN-1:0] chip_addr_sr [NCH] = '{default: '0};
    logic [ALEN-1:0] chip_addr_ap [NCH] = '{default: '0};
    logic [LEN-1:0]  chip_inst_sr [NCH][NL] = '{default: '{default: '0}};
    logic [LEN-1:0]  chip_inst_ap [NCH][NL] = '{default: '{default: '0}};

    // Predicted chip state and pending completion per channel
    logic [ALEN-1:0] pred_addr [NCH] = '{default: '0};
    logic [FW-1:0]   pred_inst [NCH] = '{default: '0};
    logic [LEN-1:0]  pred_lb [NCH];
    logic            pred_lbv [NCH];
    logic            pending [NCH] = '{default: 1'b0};

    int          drops_expected = 0;
    int          drop_seen = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    logic        frozen = 1'b0;
    logic        clk_running = 1'b0;
    logic        held_p;
    logic        held_n;

    ss_scan_controller DUT (
        .i_sys_clk           (i_sys_clk),
        .rst_sync_sys        (rst_sync_sys),
        .i_scan_clk_en       (i_scan_clk_en),
        .i_cmd_valid         (i_cmd_valid),
        .i_cmd_op            (i_cmd_op),
        .i_cmd_channel       (i_cmd_channel),
        .i_cmd_addr          (i_cmd_addr),
        .i_cmd_inst          (i_cmd_inst),
        .o_cmd_drop          (o_cmd_drop),
        .o_done              (o_done),
        .o_loopback_valid    (o_loopback_valid),
        .o_loopback_data     (o_loopback_data),
        .o_scan_clk_p        (o_scan_clk_p),
        .o_scan_clk_n        (o_scan_clk_n),
        .o_scan_reset        (o_scan_reset),
        .o_scan_update       (o_scan_update),
        .o_scan_en_inst      (o_scan_en_inst),
        .o_scan_in_inst      (o_scan_in_inst),
        .o_scan_en_address   (o_scan_en_address),
        .o_scan_in_address   (o_scan_in_address),
        .i_scan_out_loopback (scan_loopback)
    );

    initial i_sys_clk = 1'b0;
    always #2 i_sys_clk = ~i_sys_clk;

    // --------------------
    // Chip model
    // --------------------
    always @(posedge o_scan_clk_p) begin
        for (int c = 0; c < NCH; c++) begin
            if (o_scan_reset[c]) begin
                chip_addr_sr[c] <= '0;
                chip_addr_ap[c] <= '0;
                for (int l = 0; l < NL; l++) begin
                    chip_inst_sr[c][l] <= '0;
                    chip_inst_ap[c][l] <= '0;
                end
            end else begin
                if (o_scan_en_address[c]) begin
                    chip_addr_sr[c] <= {chip_addr_sr[c][ALEN-2:0], o_scan_in_address[c]};
                end
                for (int l = 0; l < NL; l++) begin
                    if (o_scan_en_inst[c]) begin
                        chip_inst_sr[c][l] <= {chip_inst_sr[c][l][LEN-2:0], o_scan_in_inst[c][l]};
                    end
                    if (o_scan_update[c]) begin
                        chip_inst_ap[c][l] <= chip_inst_sr[c][l];
                    end
                end
                if (o_scan_update[c]) begin
                    chip_addr_ap[c] <= chip_addr_sr[c];
                end
            end
        end
    end

    // Lane 0 chain output feeds back to the driver
    always_comb begin
        for (int c = 0; c < NCH; c++) begin
            scan_loopback[c] = chip_inst_sr[c][0][LEN-1];
        end
    end

    // --------------------
    // Reference and checks
    // --------------------
    // The old lane 0 contents come back out while a new frame shifts in
    function automatic void predict(
        input  scan_op_e        op,
        input  logic [ALEN-1:0] cmd_addr,
        input  logic [FW-1:0]   cmd_inst,
        input  logic [ALEN-1:0] cur_addr,
        input  logic [FW-1:0]   cur_inst,
        output logic [ALEN-1:0] nxt_addr,
        output logic [FW-1:0]   nxt_inst,
        output logic [LEN-1:0]  lb_word,
        output logic            lb_valid
    );
        nxt_addr = cur_addr;
        nxt_inst = cur_inst;
        lb_word  = '0;
        lb_valid = 1'b0;
        case (op)
            OP_RESET_CHIP: begin
                nxt_addr = '0;
                nxt_inst = '0;
            end
            OP_LOAD_ADDR: nxt_addr = cmd_addr;
            OP_LOAD_INST: begin
                lb_word  = cur_inst[LEN-1:0];
                lb_valid = 1'b1;
                nxt_inst = cmd_inst;
            end
            default: ;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_chip(input int ch);
        logic [FW-1:0] frame;
        for (int l = 0; l < NL; l++) begin
            frame[l*LEN +: LEN] = chip_inst_ap[ch][l];
        end
        check_value($sformatf("ch%0d applied address", ch), 256'(pred_addr[ch]),
                    256'(chip_addr_ap[ch]));
        check_value($sformatf("ch%0d applied frame", ch), 256'(pred_inst[ch]), 256'(frame));
    endtask

    // Completion checker
    always @(negedge i_sys_clk) begin
        if (!rst_sync_sys) begin
            if (frozen && |o_done) begin
                abort_run("o_done pulsed while the scan clock was disabled");
            end
            // Once running, the two scan clocks are always opposite
            if (clk_running) begin
                check_value("complementary scan clocks", 256'(1),
                            256'(o_scan_clk_p ^ o_scan_clk_n));
            end
            for (int c = 0; c < NCH; c++) begin
                if (o_done[c]) begin
                    if (!pending[c]) begin
                        abort_run($sformatf("o_done on channel %0d with no command running", c));
                    end
                    check_value($sformatf("ch%0d loopback valid", c), 256'(pred_lbv[c]),
                                256'(o_loopback_valid[c]));
                    if (pred_lbv[c]) begin
                        check_value($sformatf("ch%0d loopback data", c), 256'(pred_lb[c]),
                                    256'(o_loopback_data[c]));
                    end
                    check_chip(c);
                    pending[c] = 1'b0;
                end else begin
                    check_value($sformatf("ch%0d loopback valid without done", c), '0,
                                256'(o_loopback_valid[c]));
                end
            end
            if (o_cmd_drop) begin
                drop_seen++;
            end
        end
    end

    always @(posedge i_sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the commands did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    function automatic logic [FW-1:0] rand_frame();
        logic [FW-1:0] f;
        f = '0;
        for (int w = 0; w < FW / 32; w++) begin
            f = {f[FW-33:0], $urandom()};
        end
        return f;
    endfunction

    task automatic issue_cmd(input scan_op_e op, input int ch, input logic [ALEN-1:0] addr,
                             input logic [FW-1:0] inst, input logic expect_drop);
        @(posedge i_sys_clk);
        i_cmd_valid   <= 1'b1;
        i_cmd_op      <= op;
        i_cmd_channel <= 2'(ch);
        i_cmd_addr    <= addr;
        i_cmd_inst    <= inst;
        if (expect_drop) begin
            drops_expected++;
        end else begin
            predict(op, addr, inst, pred_addr[ch], pred_inst[ch], pred_addr[ch],
                    pred_inst[ch], pred_lb[ch], pred_lbv[ch]);
            pending[ch] = 1'b1;
        end
        @(posedge i_sys_clk);
        i_cmd_valid <= 1'b0;
    endtask

    task automatic wait_done(input int ch);
        while (pending[ch]) begin
            @(posedge i_sys_clk);
        end
    endtask

    initial begin
        void'($urandom(32'hec08));
        rst_sync_sys  = 1'b1;
        i_scan_clk_en = 1'b0;
        i_cmd_valid   = 1'b0;
        i_cmd_op      = OP_RESET_CHIP;
        i_cmd_channel = '0;
        i_cmd_addr    = '0;
        i_cmd_inst    = '0;
        repeat (2) @(posedge i_sys_clk);
        rst_sync_sys <= 1'b0;
        @(negedge i_sys_clk);
        check_value("idle outputs after reset", '0,
                    256'({o_scan_reset, o_scan_update, o_scan_en_inst, o_scan_en_address,
                          o_done, o_cmd_drop, o_loopback_valid, o_scan_clk_p, o_scan_clk_n}));
        @(posedge i_sys_clk);
        i_scan_clk_en <= 1'b1;
        @(posedge i_sys_clk);
        clk_running = 1'b1;

        // Address load per channel, others untouched
        for (int c = 0; c < NCH; c++) begin
            issue_cmd(OP_LOAD_ADDR, c, ALEN'($urandom()), '0, 1'b0);
            wait_done(c);
            for (int o = 0; o < NCH; o++) begin
                check_chip(o);
            end
        end

        // Random instruction loads
        for (int i = 0; i < 8; i++) begin
            issue_cmd(OP_LOAD_INST, i % NCH, '0, rand_frame(), 1'b0);
            wait_done(i % NCH);
        end

        // Chip reset clears the loopback source
        issue_cmd(OP_RESET_CHIP, 1, '0, '0, 1'b0);
        wait_done(1);
        issue_cmd(OP_LOAD_INST, 1, '0, rand_frame(), 1'b0);
        wait_done(1);

        // All channels at once, plus one command to a busy channel
        for (int c = 0; c < NCH; c++) begin
            issue_cmd(OP_LOAD_INST, c, '0, rand_frame(), 1'b0);
        end
        issue_cmd(OP_LOAD_INST, 0, '0, rand_frame(), 1'b1);
        for (int c = 0; c < NCH; c++) begin
            wait_done(c);
        end
        check_value("dropped commands", 256'(drops_expected), 256'(drop_seen));

        // Freeze the scan clock mid load
        issue_cmd(OP_LOAD_INST, 2, '0, rand_frame(), 1'b0);
        while (!o_scan_en_inst[2]) begin
            @(posedge i_sys_clk);
        end
        @(posedge i_sys_clk);
        i_scan_clk_en <= 1'b0;
        frozen = 1'b1;
        @(negedge i_sys_clk);
        held_p = o_scan_clk_p;
        held_n = o_scan_clk_n;
        repeat (200) begin
            @(negedge i_sys_clk);
            check_value("frozen scan clock", 256'({held_p, held_n}),
                        256'({o_scan_clk_p, o_scan_clk_n}));
        end
        @(posedge i_sys_clk);
        frozen = 1'b0;
        i_scan_clk_en <= 1'b1;
        wait_done(2);

        @(posedge i_sys_clk);
        check_value("dropped commands at end", 256'(drops_expected), 256'(drop_seen));
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
